//--- hw/vliwPkg.sv
package vliwPkg;

	////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////

	localparam int dataWidth = 16;
	localparam int regCount = 32;
	localparam int regAddrWidth = 5;
	// register read, execute and writeback stages behind the issue point
	localparam int pipeDepth = 3;

	// axi4-lite response codes
	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlverr = 2'b10;

	// write offsets for the two halves of a bundle
	localparam logic [7:0] slotAOffset = 8'h00;
	localparam logic [7:0] slotBOffset = 8'h04;

	////////////////////////////////////////
	// instruction encoding
	////////////////////////////////////////

	// codes 9 to 15 are unused and behave as opNop
	typedef enum logic [3:0] {
		opAdd = 4'h0,
		opSub = 4'h1,
		opAnd = 4'h2,
		opOr  = 4'h3,
		opXor = 4'h4,
		opShl = 4'h5,
		opShr = 4'h6,
		opMov = 4'h7,
		opNop = 4'h8
	} opcode_e;

	// one slot of a bundle, msb first
	typedef struct packed {
		logic regImm;
		opcode_e opcode;
		logic [regAddrWidth-1:0] dest;
		logic [regAddrWidth-1:0] src;
		logic [dataWidth-1:0] imm;
		logic spare;
	} instr_t;

	typedef struct packed {
		opcode_e opcode;
		logic [regAddrWidth-1:0] dest;
		logic [regAddrWidth-1:0] src;
		logic [dataWidth-1:0] imm;
		logic regImm;
		logic readsDest;
		logic readsSrc;
		logic writes;
	} decodedSlot_t;

	typedef struct packed {
		instr_t slotA;
		instr_t slotB;
	} bundle_t;

	////////////////////////////////////////
	// host bus, write channel only
	////////////////////////////////////////

	typedef struct packed {
		logic awvalid;
		logic [7:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
	} axiLiteReq_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
	} axiLiteRsp_t;

	////////////////////////////////////////
	// pipeline payloads
	////////////////////////////////////////

	typedef struct packed {
		logic valid;
		opcode_e opcode;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0] primVal;
		logic [dataWidth-1:0] secVal;
	} execSlot_t;

	typedef struct packed {
		logic valid;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0] data;
	} wbLane_t;

endpackage

//--- hw/bundleFetch.sv
module bundleFetch
	import vliwPkg::*;
(
	input  logic        clock_i,
	input  logic        reset_i,
	input  axiLiteReq_t axiReq_i,
	output axiLiteRsp_t axiRsp_o,
	input  logic        issue_i,
	output bundle_t     bundle_o,
	output logic        bundleValid_o
);

	// address and data holding registers
	logic awHeld;
	logic wHeld;
	logic [7:0] awAddr;
	logic [31:0] wData;
	logic [3:0] wStrb;

	// response channel
	logic bValid;
	logic [1:0] bResp;

	// slot a latch and the one-deep issue buffer
	instr_t slotA;
	bundle_t buffer;
	logic bufValid;

	logic awReady;
	logic wReady;
	logic awFire;
	logic wFire;
	logic bFire;
	logic isSlotA;
	logic isSlotB;
	logic doWrite;
	logic commit;

	// byte lanes not strobed keep their old contents
	function automatic logic [31:0] mergeStrobe(
		input logic [31:0] oldWord,
		input logic [31:0] newWord,
		input logic [3:0] strb
	);
		logic [31:0] merged;
		merged = oldWord;
		for (int i = 0; i < 4; i++)
		begin
			if (strb[i])
				merged[8*i +: 8] = newWord[8*i +: 8];
		end
		return merged;
	endfunction

	////////////////////////////////////////
	// handshakes
	////////////////////////////////////////

	// nothing new is taken while a response is outstanding
	assign awReady = !awHeld && !bValid;
	assign wReady = !wHeld && !bValid;
	assign awFire = axiReq_i.awvalid && awReady;
	assign wFire = axiReq_i.wvalid && wReady;
	assign bFire = bValid && axiReq_i.bready;

	assign isSlotA = (awAddr == slotAOffset);
	assign isSlotB = (awAddr == slotBOffset);

	// slot b stalls here while the buffer is still occupied
	// freeing and refilling in the same cycle is allowed
	assign doWrite = awHeld && wHeld && !bValid && (!isSlotB || !bufValid || issue_i);
	assign commit = doWrite && isSlotB;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			awHeld <= 1'b0;
			wHeld <= 1'b0;
			bValid <= 1'b0;
			bufValid <= 1'b0;
		end
		else
		begin
			if (doWrite)
				awHeld <= 1'b0;
			else if (awFire)
				awHeld <= 1'b1;
			if (doWrite)
				wHeld <= 1'b0;
			else if (wFire)
				wHeld <= 1'b1;
			if (doWrite)
				bValid <= 1'b1;
			else if (bFire)
				bValid <= 1'b0;
			// buffer empties on issue unless a new bundle lands at once
			if (commit)
				bufValid <= 1'b1;
			else if (issue_i)
				bufValid <= 1'b0;
		end
	end

	////////////////////////////////////////
	// payload
	////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (awFire)
			awAddr <= axiReq_i.awaddr;
		if (wFire)
		begin
			wData <= axiReq_i.wdata;
			wStrb <= axiReq_i.wstrb;
		end
		// unknown offsets only get an error response
		if (doWrite)
			bResp <= (isSlotA || isSlotB) ? respOkay : respSlverr;
		if (doWrite && isSlotA)
			slotA <= instr_t'(mergeStrobe(slotA, wData, wStrb));
		if (commit)
		begin
			buffer.slotA <= slotA;
			buffer.slotB <= instr_t'(mergeStrobe(buffer.slotB, wData, wStrb));
		end
	end

	assign axiRsp_o.awready = awReady;
	assign axiRsp_o.wready = wReady;
	assign axiRsp_o.bvalid = bValid;
	assign axiRsp_o.bresp = bResp;

	assign bundle_o = buffer;
	assign bundleValid_o = bufValid;

endmodule

//--- hw/slotDecode.sv
module slotDecode
	import vliwPkg::*;
(
	input  instr_t       instr_i,
	output decodedSlot_t slot_o
);

	logic writes;
	logic readsDest;

	// register-use flags per opcode
	always_comb
	begin
		case (instr_i.opcode)
			opAdd, opSub, opAnd, opOr, opXor, opShl, opShr:
			begin
				writes = 1'b1;
				readsDest = 1'b1;
			end
			// move overwrites dest without looking at it
			opMov:
			begin
				writes = 1'b1;
				readsDest = 1'b0;
			end
			// opNop and every unused code
			default:
			begin
				writes = 1'b0;
				readsDest = 1'b0;
			end
		endcase
	end

	assign slot_o.opcode = instr_i.opcode;
	assign slot_o.dest = instr_i.dest;
	assign slot_o.src = instr_i.src;
	assign slot_o.imm = instr_i.imm;
	assign slot_o.regImm = instr_i.regImm;
	assign slot_o.readsDest = readsDest;
	assign slot_o.writes = writes;
	// src register is the second operand of any writing op in reg-reg form,
	// a register move included
	assign slot_o.readsSrc = writes && !instr_i.regImm;

endmodule

//--- hw/hazardCheck.sv
module hazardCheck
	import vliwPkg::*;
(
	input  logic         clock_i,
	input  logic         reset_i,
	input  logic         bundleValid_i,
	input  decodedSlot_t slotA_i,
	input  decodedSlot_t slotB_i,
	output logic         issue_o
);

	// stage 0 is register read, stage 2 is writeback
	logic [pipeDepth-1:0] pendA;
	logic [pipeDepth-1:0] pendB;
	logic [pipeDepth-1:0][regAddrWidth-1:0] destA;
	logic [pipeDepth-1:0][regAddrWidth-1:0] destB;
	logic hazard;

	// true when any in-flight lane still has to write addr
	function automatic logic regBusy(input logic [regAddrWidth-1:0] addr);
		logic busy;
		busy = 1'b0;
		for (int s = 0; s < pipeDepth; s++)
		begin
			if ((pendA[s] && destA[s] == addr) || (pendB[s] && destB[s] == addr))
				busy = 1'b1;
		end
		return busy;
	endfunction

	////////////////////////////////////////
	// issue decision
	////////////////////////////////////////

	// a write in the writeback stage lands at the end of the cycle,
	// so it still blocks a reader this cycle
	always_comb
	begin
		hazard = (slotA_i.readsDest && regBusy(slotA_i.dest))
			|| (slotA_i.readsSrc && regBusy(slotA_i.src))
			|| (slotB_i.readsDest && regBusy(slotB_i.dest))
			|| (slotB_i.readsSrc && regBusy(slotB_i.src));
	end

	assign issue_o = bundleValid_i && !hazard;

	////////////////////////////////////////
	// scoreboard shift
	////////////////////////////////////////

	// the pipe never stalls after issue, so entries shift every cycle
	// and fall out once their bundle has written back
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			pendA <= '0;
			pendB <= '0;
		end
		else
		begin
			pendA <= {pendA[pipeDepth-2:0], issue_o && slotA_i.writes};
			pendB <= {pendB[pipeDepth-2:0], issue_o && slotB_i.writes};
		end
	end

	always_ff @(posedge clock_i)
	begin
		destA <= {destA[pipeDepth-2:0], slotA_i.dest};
		destB <= {destB[pipeDepth-2:0], slotB_i.dest};
	end

endmodule

//--- hw/registerFile.sv
module registerFile
	import vliwPkg::*;
(
	input  logic         clock_i,
	input  logic         reset_i,
	input  logic         issue_i,
	input  decodedSlot_t slotA_i,
	input  decodedSlot_t slotB_i,
	input  wbLane_t      wbA_i,
	input  wbLane_t      wbB_i,
	output execSlot_t    execA_o,
	output execSlot_t    execB_o
);

	logic [dataWidth-1:0] regs [regCount];

	// four read ports
	logic [dataWidth-1:0] rdDestA;
	logic [dataWidth-1:0] rdSrcA;
	logic [dataWidth-1:0] rdDestB;
	logic [dataWidth-1:0] rdSrcB;

	// operand selection, same for both lanes
	function automatic execSlot_t buildExec(
		input decodedSlot_t slot,
		input logic [dataWidth-1:0] destVal,
		input logic [dataWidth-1:0] srcVal
	);
		execSlot_t ex;
		ex.valid = 1'b0;
		ex.opcode = slot.opcode;
		ex.dest = slot.dest;
		ex.primVal = destVal;
		ex.secVal = slot.regImm ? slot.imm : srcVal;
		return ex;
	endfunction

	////////////////////////////////////////
	// write ports
	////////////////////////////////////////

	// lane b is written last so it wins on equal addresses
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (wbA_i.valid)
				regs[wbA_i.dest] <= wbA_i.data;
			if (wbB_i.valid)
				regs[wbB_i.dest] <= wbB_i.data;
		end
	end

	////////////////////////////////////////
	// read stage
	////////////////////////////////////////

	assign rdDestA = regs[slotA_i.dest];
	assign rdSrcA = regs[slotA_i.src];
	assign rdDestB = regs[slotB_i.dest];
	assign rdSrcB = regs[slotB_i.src];

	// both lanes sample the file before their own bundle writes
	always_ff @(posedge clock_i)
	begin
		execA_o <= buildExec(slotA_i, rdDestA, rdSrcA);
		execB_o <= buildExec(slotB_i, rdDestB, rdSrcB);
		if (reset_i)
		begin
			execA_o.valid <= 1'b0;
			execB_o.valid <= 1'b0;
		end
		else
		begin
			execA_o.valid <= issue_i;
			execB_o.valid <= issue_i;
		end
	end

endmodule

//--- hw/arithmeticUnit.sv
module arithmeticUnit
	import vliwPkg::*;
(
	input  logic      clock_i,
	input  logic      reset_i,
	input  execSlot_t exec_i,
	output wbLane_t   wb_o
);

	logic writesOp;
	logic [dataWidth-1:0] result;
	// execute stage register ahead of writeback
	wbLane_t execStage;

	// shifts use the low 4 bits of the second operand
	always_comb
	begin
		writesOp = 1'b1;
		result = '0;
		case (exec_i.opcode)
			opAdd: result = exec_i.primVal + exec_i.secVal;
			opSub: result = exec_i.primVal - exec_i.secVal;
			opAnd: result = exec_i.primVal & exec_i.secVal;
			opOr: result = exec_i.primVal | exec_i.secVal;
			opXor: result = exec_i.primVal ^ exec_i.secVal;
			opShl: result = exec_i.primVal << exec_i.secVal[3:0];
			opShr: result = exec_i.primVal >> exec_i.secVal[3:0];
			opMov: result = exec_i.secVal;
			// nop and unused codes never write back
			default: writesOp = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// execute and writeback registers
	////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		execStage.dest <= exec_i.dest;
		execStage.data <= result;
		wb_o <= execStage;
		if (reset_i)
		begin
			execStage.valid <= 1'b0;
			wb_o.valid <= 1'b0;
		end
		else
		begin
			execStage.valid <= exec_i.valid && writesOp;
		end
	end

endmodule

//--- hw/vliwCore.sv
module vliwCore
	import vliwPkg::*;
(
	input  logic        clock_i,
	input  logic        reset_i,
	input  axiLiteReq_t axiReq_i,
	output axiLiteRsp_t axiRsp_o,
	output wbLane_t     wbA_o,
	output wbLane_t     wbB_o
);

	// fetch out, decode and scoreboard in
	bundle_t bundle;
	logic bundleValid;
	logic issue;

	// decode out
	decodedSlot_t slotA;
	decodedSlot_t slotB;

	// register read out, lanes in
	execSlot_t execA;
	execSlot_t execB;

	////////////////////////////////////////
	// front end
	////////////////////////////////////////

	bundleFetch fetch (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.axiReq_i     (axiReq_i),
		.axiRsp_o     (axiRsp_o),
		.issue_i      (issue),
		.bundle_o     (bundle),
		.bundleValid_o(bundleValid)
	);

	slotDecode decodeA (
		.instr_i(bundle.slotA),
		.slot_o (slotA)
	);

	slotDecode decodeB (
		.instr_i(bundle.slotB),
		.slot_o (slotB)
	);

	// holds the buffered bundle back while its sources are in flight
	hazardCheck scoreboard (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.bundleValid_i(bundleValid),
		.slotA_i      (slotA),
		.slotB_i      (slotB),
		.issue_o      (issue)
	);

	////////////////////////////////////////
	// back end
	////////////////////////////////////////

	// writebacks feed back into the file and leave at the top ports
	registerFile registers (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.issue_i(issue),
		.slotA_i(slotA),
		.slotB_i(slotB),
		.wbA_i  (wbA_o),
		.wbB_i  (wbB_o),
		.execA_o(execA),
		.execB_o(execB)
	);

	arithmeticUnit laneA (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.exec_i (execA),
		.wb_o   (wbA_o)
	);

	arithmeticUnit laneB (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.exec_i (execB),
		.wb_o   (wbB_o)
	);

endmodule

//--- dv/vliwCoreProps.sv
module vliwCoreProps
	import vliwPkg::*;
(
	input  logic        clock_i,
	input  logic        reset_i,
	input  axiLiteReq_t axiReq_i,
	input  axiLiteRsp_t axiRsp_i,
	input  wbLane_t     wbA_i,
	input  wbLane_t     wbB_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// failure counts per property, summed by tbTop
	int bvalidFails = 0;
	int readyFails = 0;
	int resetFails = 0;

	////////////////////////////////////////
	// write response channel
	////////////////////////////////////////

	// response and its code hold until the host takes them
	bvalidHeld: assert property (@(posedge clock_i) disable iff (reset_i)
		axiRsp_i.bvalid && !axiReq_i.bready |=> axiRsp_i.bvalid && $stable(axiRsp_i.bresp))
	else
	begin
		bvalidFails++;
		$error("bvalid dropped or bresp changed before bready");
	end

	// no new address or data while a response is outstanding
	readyLowOnResp: assert property (@(posedge clock_i) disable iff (reset_i)
		axiRsp_i.bvalid |-> !axiRsp_i.awready && !axiRsp_i.wready)
	else
	begin
		readyFails++;
		$error("awready or wready high while bvalid is high");
	end

	////////////////////////////////////////
	// writeback lanes
	////////////////////////////////////////

	resetClearsWb: assert property (@(posedge clock_i)
		reset_i |=> !wbA_i.valid && !wbB_i.valid)
	else
	begin
		resetFails++;
		$error("writeback valid in the cycle after reset");
	end

endmodule

//--- dv/coreChecker.sv
module coreChecker
	import vliwPkg::*;
(
	input  logic        clock_i,
	input  logic        reset_i,
	input  axiLiteReq_t axiReq_i,
	input  axiLiteRsp_t axiRsp_i,
	input  wbLane_t     wbA_i,
	input  wbLane_t     wbB_i,
	output int          errorCount_o,
	output int          checkCount_o,
	output logic        idle_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// both lanes of one bundle, as they should leave the core
	typedef struct packed {
		wbLane_t laneA;
		wbLane_t laneB;
	} expectWb_t;

	// architectural state of the sequential model
	logic [dataWidth-1:0] model [regCount];
	instr_t slotALatch;
	expectWb_t expected [$];
	expectWb_t head;

	// last accepted address and data
	logic [7:0] capAddr;
	logic [31:0] capData;

	logic prevBvalid;
	logic prevStall;
	logic [1:0] prevBresp;
	logic afterReset;
	int pending;
	int errors;
	int checks;

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// one slot on values read before its bundle
	function automatic wbLane_t executeSlot(
		input instr_t word,
		input logic [dataWidth-1:0] destVal,
		input logic [dataWidth-1:0] srcVal
	);
		logic [dataWidth-1:0] second;
		wbLane_t lane;
		second = word.regImm ? word.imm : srcVal;
		lane.valid = 1'b1;
		lane.dest = word.dest;
		lane.data = '0;
		case (word.opcode)
			opAdd: lane.data = destVal + second;
			opSub: lane.data = destVal - second;
			opAnd: lane.data = destVal & second;
			opOr: lane.data = destVal | second;
			opXor: lane.data = destVal ^ second;
			opShl: lane.data = destVal << second[3:0];
			opShr: lane.data = destVal >> second[3:0];
			opMov: lane.data = second;
			// nop and codes 9 to 15
			default: lane.valid = 1'b0;
		endcase
		return lane;
	endfunction

	// lane a writes first, so lane b wins on a shared dest
	task automatic commitBundle(input instr_t slotB);
		expectWb_t want;
		want.laneA = executeSlot(slotALatch, model[slotALatch.dest], model[slotALatch.src]);
		want.laneB = executeSlot(slotB, model[slotB.dest], model[slotB.src]);
		if (want.laneA.valid)
			model[want.laneA.dest] = want.laneA.data;
		if (want.laneB.valid)
			model[want.laneB.dest] = want.laneB.data;
		if (want.laneA.valid || want.laneB.valid)
			expected.push_back(want);
	endtask

	// a rising bvalid means one write has taken effect
	task automatic handleWrite();
		logic [1:0] wantResp;
		wantResp = (capAddr == slotAOffset || capAddr == slotBOffset) ? respOkay : respSlverr;
		if (axiRsp_i.bresp !== wantResp)
		begin
			errors++;
			$display("Error bresp: expected %h got %h at offset %h",
				wantResp, axiRsp_i.bresp, capAddr);
		end
		if (capAddr == slotAOffset)
			slotALatch = instr_t'(capData);
		else if (capAddr == slotBOffset)
			commitBundle(instr_t'(capData));
	endtask

	task automatic compareLane(input string name, input wbLane_t want, input wbLane_t got);
		checks++;
		if (got.valid !== want.valid)
		begin
			errors++;
			$display("Error %s.valid: expected %h got %h", name, want.valid, got.valid);
		end
		else if (want.valid && got.dest !== want.dest)
		begin
			errors++;
			$display("Error %s.dest: expected %h got %h", name, want.dest, got.dest);
		end
		else if (want.valid && got.data !== want.data)
		begin
			errors++;
			$display("Error %s.data: expected %h got %h", name, want.data, got.data);
		end
	endtask

	////////////////////////////////////////
	// monitor
	////////////////////////////////////////

	initial
	begin
		errors = 0;
		checks = 0;
		pending = 0;
	end

	always @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < regCount; i++)
				model[i] = '0;
			expected.delete();
			slotALatch = '0;
			prevBvalid = 1'b0;
			prevStall = 1'b0;
			prevBresp = respOkay;
			afterReset = 1'b1;
		end
		else
		begin
			// first cycle out of reset
			if (afterReset && (axiRsp_i.bvalid || wbA_i.valid || wbB_i.valid))
			begin
				errors++;
				$display("Error bvalid/wbA_o.valid/wbB_o.valid after reset: expected 0 got %h%h%h",
					axiRsp_i.bvalid, wbA_i.valid, wbB_i.valid);
			end
			afterReset = 1'b0;
			if (prevStall && (!axiRsp_i.bvalid || axiRsp_i.bresp !== prevBresp))
			begin
				errors++;
				$display("response changed while bready was held low");
			end
			if (axiRsp_i.bvalid && ((axiReq_i.awvalid && axiRsp_i.awready)
				|| (axiReq_i.wvalid && axiRsp_i.wready)))
			begin
				errors++;
				$display("address or data accepted while a response was still pending");
			end
			if (axiReq_i.awvalid && axiRsp_i.awready)
				capAddr = axiReq_i.awaddr;
			if (axiReq_i.wvalid && axiRsp_i.wready)
				capData = axiReq_i.wdata;
			if (axiRsp_i.bvalid && !prevBvalid)
				handleWrite();
			// writebacks leave in bundle order, both lanes together
			if (wbA_i.valid || wbB_i.valid)
			begin
				if (expected.size() == 0)
				begin
					errors++;
					$display("writeback arrived with no bundle outstanding");
				end
				else
				begin
					head = expected.pop_front();
					compareLane("wbA_o", head.laneA, wbA_i);
					compareLane("wbB_o", head.laneB, wbB_i);
				end
			end
			prevBvalid = axiRsp_i.bvalid;
			prevStall = axiRsp_i.bvalid && !axiReq_i.bready;
			prevBresp = axiRsp_i.bresp;
		end
		pending = expected.size();
	end

	assign errorCount_o = errors;
	assign checkCount_o = checks;
	assign idle_o = (pending == 0) && !axiRsp_i.bvalid;

endmodule

//--- dv/tbTop.sv
module tbTop
	import vliwPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// bundles per test, error writes of test 5 count as bundles
	localparam int resetBundles = 1;
	localparam int regRegBundles = 40;
	localparam int regImmBundles = 32;
	localparam int sameBundleBundles = 5;
	localparam int badOffsetBundles = 8;
	localparam int pressureBundles = 30;
	localparam int cyclesPerBundle = 20;
	localparam int cycleLimit = cyclesPerBundle * (resetBundles + regRegBundles
		+ regImmBundles + sameBundleBundles + badOffsetBundles + pressureBundles);
	localparam int seed = 94471;

	logic clock;
	logic reset;
	axiLiteReq_t axiReq;
	axiLiteRsp_t axiRsp;
	wbLane_t wbA;
	wbLane_t wbB;
	int checkerErrors;
	int checkerChecks;
	logic checkerIdle;
	int cycleCount;
	int testNumber;
	int errorsBefore;
	int checksBefore;

	vliwCore DUT (
		.clock_i (clock),
		.reset_i (reset),
		.axiReq_i(axiReq),
		.axiRsp_o(axiRsp),
		.wbA_o   (wbA),
		.wbB_o   (wbB)
	);

	coreChecker coreCheck (
		.clock_i     (clock),
		.reset_i     (reset),
		.axiReq_i    (axiReq),
		.axiRsp_i    (axiRsp),
		.wbA_i       (wbA),
		.wbB_i       (wbB),
		.errorCount_o(checkerErrors),
		.checkCount_o(checkerChecks),
		.idle_o      (checkerIdle)
	);

	bind vliwCore vliwCoreProps props (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.axiReq_i(axiReq_i),
		.axiRsp_i(axiRsp_o),
		.wbA_i   (wbA_o),
		.wbB_i   (wbB_o)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// watchdog on the whole run
	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout after %0d cycles, a response or writeback never arrived", cycleCount);
		$display("Testbench failed");
		$finish;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic int totalFails();
		return checkerErrors + DUT.props.bvalidFails + DUT.props.readyFails
			+ DUT.props.resetFails;
	endfunction

	function automatic instr_t makeInstr(
		input logic regImm,
		input logic [3:0] op,
		input logic [regAddrWidth-1:0] dest,
		input logic [regAddrWidth-1:0] src,
		input logic [dataWidth-1:0] imm
	);
		instr_t word;
		word.regImm = regImm;
		word.opcode = opcode_e'(op);
		word.dest = dest;
		word.src = src;
		word.imm = imm;
		word.spare = 1'b0;
		return word;
	endfunction

	// registers 0 to 7 only, so bundles collide often
	function automatic instr_t randomInstr(input logic regImm, input logic [3:0] op);
		return makeInstr(regImm, op, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
			16'($urandom));
	endfunction

	// aw and w together, then b after holdCycles of back-pressure
	task automatic busWrite(input logic [7:0] addr, input logic [31:0] data,
		input int holdCycles);
		logic awDone;
		logic wDone;
		logic awFire;
		logic wFire;
		awDone = 1'b0;
		wDone = 1'b0;
		@(posedge clock);
		axiReq.awvalid <= 1'b1;
		axiReq.awaddr <= addr;
		axiReq.wvalid <= 1'b1;
		axiReq.wdata <= data;
		axiReq.wstrb <= 4'hF;
		while (!(awDone && wDone))
		begin
			@(negedge clock);
			awFire = axiReq.awvalid && axiRsp.awready;
			wFire = axiReq.wvalid && axiRsp.wready;
			@(posedge clock);
			if (awFire)
			begin
				axiReq.awvalid <= 1'b0;
				awDone = 1'b1;
			end
			if (wFire)
			begin
				axiReq.wvalid <= 1'b0;
				wDone = 1'b1;
			end
		end
		@(negedge clock);
		while (!axiRsp.bvalid)
			@(negedge clock);
		// offer a stray address and data while the response is held back
		if (holdCycles > 0)
		begin
			@(posedge clock);
			axiReq.awvalid <= 1'b1;
			axiReq.wvalid <= 1'b1;
			repeat (holdCycles - 1) @(posedge clock);
		end
		@(posedge clock);
		axiReq.awvalid <= 1'b0;
		axiReq.wvalid <= 1'b0;
		axiReq.bready <= 1'b1;
		@(negedge clock);
		while (!(axiRsp.bvalid && axiReq.bready))
			@(negedge clock);
		@(posedge clock);
		axiReq.bready <= 1'b0;
	endtask

	task automatic sendBundle(input instr_t slotA, input instr_t slotB, input int holdCycles);
		busWrite(slotAOffset, slotA, holdCycles);
		busWrite(slotBOffset, slotB, holdCycles);
	endtask

	task automatic beginTest();
		testNumber++;
		errorsBefore = totalFails();
		checksBefore = checkerChecks;
	endtask

	// wait for the model queue to empty, then a few quiet cycles
	task automatic endTest(input string name, input int bundles);
		@(negedge clock);
		while (!checkerIdle)
			@(negedge clock);
		repeat (4) @(negedge clock);
		$display("test %0d %s: %0d bundles, %0d checks, %0d errors", testNumber, name,
			bundles, checkerChecks - checksBefore, totalFails() - errorsBefore);
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial
	begin
		int hold;
		logic [7:0] badAddr;
		void'($urandom(seed));
		testNumber = 0;
		axiReq <= '0;
		reset <= 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		// moves of immediates straight out of reset
		beginTest();
		sendBundle(makeInstr(1'b1, opMov, 5'd6, 5'd0, 16'hBEEF),
			makeInstr(1'b1, opMov, 5'd7, 5'd0, 16'h0042), 0);
		endTest("reset and immediate moves", resetBundles);

		beginTest();
		for (int i = 0; i < regRegBundles; i++)
			sendBundle(randomInstr(1'b0, 4'($urandom_range(0, 8))),
				randomInstr(1'b0, 4'($urandom_range(0, 8))), 0);
		endTest("register-register random", regRegBundles);

		// slot a walks through all 16 codes twice
		beginTest();
		for (int i = 0; i < regImmBundles; i++)
			sendBundle(randomInstr(1'b1, 4'(i % 16)),
				randomInstr(1'b1, 4'($urandom_range(0, 15))), 0);
		endTest("register-immediate all opcodes", regImmBundles);

		// old values inside a bundle, lane b wins on a shared dest
		beginTest();
		sendBundle(makeInstr(1'b1, opMov, 5'd1, 5'd0, 16'h1234),
			makeInstr(1'b1, opMov, 5'd2, 5'd0, 16'h00F0), 0);
		sendBundle(makeInstr(1'b0, opAdd, 5'd1, 5'd2, 16'h0000),
			makeInstr(1'b0, opMov, 5'd2, 5'd1, 16'h0000), 0);
		sendBundle(makeInstr(1'b1, opMov, 5'd3, 5'd0, 16'hAAAA),
			makeInstr(1'b1, opMov, 5'd3, 5'd0, 16'h5555), 0);
		sendBundle(makeInstr(1'b0, opMov, 5'd4, 5'd3, 16'h0000),
			makeInstr(1'b1, opXor, 5'd3, 5'd0, 16'hFFFF), 0);
		sendBundle(makeInstr(1'b0, opOr, 5'd5, 5'd4, 16'h0000),
			makeInstr(1'b0, opSub, 5'd1, 5'd2, 16'h0000), 0);
		endTest("same-bundle rules", sameBundleBundles);

		// offsets 0x08 to 0xfc, never 0x0 or 0x4
		// the stray write sits between the halves so slot a must survive it
		beginTest();
		for (int i = 0; i < badOffsetBundles / 2; i++)
		begin
			badAddr = 8'($urandom_range(2, 63) * 4);
			busWrite(slotAOffset, randomInstr(1'b1, 4'($urandom_range(0, 8))), 0);
			busWrite(badAddr, $urandom, 0);
			busWrite(slotBOffset, randomInstr(1'b0, 4'($urandom_range(0, 8))), 0);
		end
		endTest("unknown offsets", badOffsetBundles);

		beginTest();
		for (int i = 0; i < pressureBundles; i++)
		begin
			hold = int'($urandom_range(1, 4));
			sendBundle(randomInstr(1'($urandom), 4'($urandom_range(0, 15))),
				randomInstr(1'($urandom), 4'($urandom_range(0, 15))), hold);
		end
		endTest("bready back-pressure", pressureBundles);

		$display("%0d tests, %0d checks, %0d errors", testNumber, checkerChecks, totalFails());
		if (totalFails() == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- sim.f
hw/vliwPkg.sv
hw/bundleFetch.sv
hw/slotDecode.sv
hw/hazardCheck.sv
hw/registerFile.sv
hw/arithmeticUnit.sv
hw/vliwCore.sv
dv/vliwCoreProps.sv
dv/coreChecker.sv
dv/tbTop.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tbTop
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
